/* verilog/cachePkg.sv */
package cachePkg;

	// Cache geometry
	localparam int lineCount = 64;
	localparam int indexWidth = 6;
	localparam int tagWidth = 7;
	localparam int adrWidth = 13; // index plus tag

	// Line layout
	localparam int laneCount = 8;
	localparam int dataWidth = 64;

	// Wishbone slave controller
	typedef enum logic [1:0]
	{
		Idle,
		Lookup,
		Respond
	} busState_t;

	// Low bits of the line address select the line
	function automatic logic [indexWidth-1:0] indexOf(input logic [adrWidth-1:0] adr);
		return adr[indexWidth-1:0];
	endfunction

	// Everything above the index is kept as the tag
	function automatic logic [tagWidth-1:0] tagOf(input logic [adrWidth-1:0] adr);
		return adr[adrWidth-1:indexWidth];
	endfunction

endpackage

/* verilog/busControl.sv */
module busControl
	import cachePkg::*;
(
	input  logic                  clk,
	input  logic                  reset,

	// Wishbone slave side
	input  logic                  cyc,
	input  logic                  stb,
	input  logic                  we,
	input  logic [adrWidth-1:0]   adr,
	input  logic [laneCount-1:0]  sel,
	input  logic [dataWidth-1:0]  datIn,
	output logic [dataWidth-1:0]  datOut,
	output logic                  ack,
	output logic                  err,

	// Lookup results from the stores
	input  logic                  hit,
	input  logic [dataWidth-1:0]  lineData,

	// Store requests
	output logic [indexWidth-1:0] reqIndex,
	output logic [tagWidth-1:0]   reqTag,
	output logic                  tagWrite,
	output logic [laneCount-1:0]  laneWrite,
	output logic [dataWidth-1:0]  writeData,
	output logic                  clearOthers
);

	busState_t state;
	logic request;
	logic weReg;
	logic [laneCount-1:0] selReg;
	logic responding;
	logic commit;
	logic readHit;

	assign request = cyc && stb;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= Idle;
		end
		else
		begin
			case (state)
				Idle:
				begin
					if (request)
						state <= Lookup;
				end
				Lookup:
				begin
					state <= Respond; // stores read during this cycle
				end
				Respond:
				begin
					state <= Idle;
				end
				default:
				begin
					state <= Idle;
				end
			endcase
		end
	end

	// Request held until the response is done
	always_ff @(posedge clk)
	begin
		if (state == Idle && request)
		begin
			weReg <= we;
			selReg <= sel;
			writeData <= datIn;
			reqIndex <= indexOf(adr);
			reqTag <= tagOf(adr);
		end
	end

	assign responding = (state == Respond);
	assign commit = responding && weReg;
	assign readHit = responding && !weReg && hit;

	// Writes land at the edge that leaves Respond
	assign tagWrite = commit;
	assign laneWrite = commit ? selReg : '0;
	assign clearOthers = commit && !hit; // miss replaces the whole line

	// Writes always succeed and reads only on a hit
	assign ack = responding && (weReg || hit);
	assign err = responding && !weReg && !hit;
	assign datOut = readHit ? lineData : '0;

	// A single response kind, two edges after the request was taken
	assert property (@(posedge clk) disable iff (reset)
		(ack || err) |-> (ack != err) && $past(state == Idle && request, 2))
		else $error("response not single or not two edges after its request");

	// Master must still be holding its request when answered
	assert property (@(posedge clk) disable iff (reset) (ack || err) |-> (cyc && stb))
		else $error("response without a pending request");

endmodule

/* verilog/tagStore.sv */
module tagStore
	import cachePkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [indexWidth-1:0] reqIndex,
	input  logic [tagWidth-1:0]   reqTag,
	input  logic                  tagWrite,
	output logic                  hit
);

	logic [tagWidth-1:0] tags [lineCount];
	logic [lineCount-1:0] valid;
	logic [tagWidth-1:0] tagRead;
	logic validRead;

	// Valid bits are the only state cleared by reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid <= '0;
		end
		else if (tagWrite)
		begin
			valid[reqIndex] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (tagWrite)
			tags[reqIndex] <= reqTag;
	end

	// One-cycle read of the indexed entry
	always_ff @(posedge clk)
	begin
		tagRead <= tags[reqIndex];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			validRead <= 1'b0;
		else
			validRead <= valid[reqIndex];
	end

	assign hit = validRead && (tagRead == reqTag);

endmodule

/* verilog/dataStore.sv */
module dataStore
	import cachePkg::*;
(
	input  logic                  clk,
	input  logic [indexWidth-1:0] reqIndex,
	input  logic [laneCount-1:0]  laneWrite,
	input  logic [dataWidth-1:0]  writeData,
	input  logic                  clearOthers,
	output logic [dataWidth-1:0]  lineData
);

	// Each line viewed as byte lanes
	logic [laneCount-1:0][dataWidth/laneCount-1:0] lines [lineCount];
	logic [laneCount-1:0][dataWidth/laneCount-1:0] writeLanes;

	assign writeLanes = writeData;

	// Selected lanes take new bytes and the rest are zeroed on a replace
	always_ff @(posedge clk)
	begin
		for (int lane = 0; lane < laneCount; lane++)
		begin
			if (laneWrite[lane])
			begin
				lines[reqIndex][lane] <= writeLanes[lane];
			end
			else if (clearOthers)
			begin
				lines[reqIndex][lane] <= '0;
			end
		end
	end

	// Registered read sees the line before a same-edge write
	always_ff @(posedge clk)
	begin
		lineData <= lines[reqIndex];
	end

	assert property (@(posedge clk) !$isunknown(laneWrite))
		else $error("lane write enables unknown");

endmodule

/* verilog/cacheTop.sv */
module cacheTop
	import cachePkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [adrWidth-1:0]  adr,
	input  logic [laneCount-1:0] sel,
	input  logic [dataWidth-1:0] datIn,
	output logic [dataWidth-1:0] datOut,
	output logic                 ack,
	output logic                 err
);

	logic [indexWidth-1:0] reqIndex;
	logic [tagWidth-1:0] reqTag;
	logic tagWrite;
	logic [laneCount-1:0] laneWrite;
	logic [dataWidth-1:0] writeData;
	logic clearOthers;
	logic hit;
	logic [dataWidth-1:0] lineData;

	busControl control
	(
		.clk         (clk),
		.reset       (reset),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.sel         (sel),
		.datIn       (datIn),
		.datOut      (datOut),
		.ack         (ack),
		.err         (err),
		.hit         (hit),
		.lineData    (lineData),
		.reqIndex    (reqIndex),
		.reqTag      (reqTag),
		.tagWrite    (tagWrite),
		.laneWrite   (laneWrite),
		.writeData   (writeData),
		.clearOthers (clearOthers)
	);

	// Tag and valid per line
	tagStore tags
	(
		.clk      (clk),
		.reset    (reset),
		.reqIndex (reqIndex),
		.reqTag   (reqTag),
		.tagWrite (tagWrite),
		.hit      (hit)
	);

	dataStore data
	(
		.clk         (clk),
		.reqIndex    (reqIndex),
		.laneWrite   (laneWrite),
		.writeData   (writeData),
		.clearOthers (clearOthers),
		.lineData    (lineData)
	);

endmodule

/* verification/cacheChecker.sv */
module cacheChecker
	import cachePkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ack,
	input  logic                 err,
	input  logic [dataWidth-1:0] datOut,
	input  logic                 expAck,
	input  logic [dataWidth-1:0] expData,
	input  int                   testNum,
	output int                   checkCount,
	output int                   errorCount
);

	int checks = 0;
	int errors = 0;

	assign checkCount = checks;
	assign errorCount = errors;

	// Response is stable in the middle of the Respond cycle
	always @(negedge clk)
	begin
		if (!reset && (ack || err))
		begin
			checks++;
			if (ack !== expAck || err !== !expAck)
			begin
				errors++;
				$display("test %0d: slave answered with %s where %s was expected",
					testNum, (ack && err) ? "both ack and err" : (ack ? "ack" : "err"),
					expAck ? "ack" : "err");
			end
			else if (datOut !== expData)
			begin
				errors++;
				$display("ERR %0t: test %0d returned data %h, expected %h",
					$time, testNum, datOut, expData);
			end
			else
			begin
				$display("test %0d ok (%s)", testNum, ack ? "ack" : "err");
			end
		end
	end

endmodule

/* verification/cacheTb.sv */
module cacheTb
	import cachePkg::*;
();

	typedef struct
	{
		logic                 we;
		logic [adrWidth-1:0]  adr;
		logic [laneCount-1:0] sel;
		logic [dataWidth-1:0] datIn;
		logic                 expAck;
		logic [dataWidth-1:0] expData;
		logic                 pulseReset;
	} test_t;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [adrWidth-1:0] adr;
	logic [laneCount-1:0] sel;
	logic [dataWidth-1:0] datIn;
	logic [dataWidth-1:0] datOut;
	logic ack;
	logic err;

	logic expAck;
	logic [dataWidth-1:0] expData;
	int curTest;
	int checkCount;
	int errorCount;
	int cycleLimit = 0;
	int cycleCount = 0;

	test_t tests[$];
	logic pendingReset;

	// Expected cache contents while the table is built
	logic [lineCount-1:0] modelValid;
	logic [tagWidth-1:0] modelTag [lineCount];
	logic [dataWidth-1:0] modelLine [lineCount];

	cacheTop DUT
	(
		.clk    (clk),
		.reset  (reset),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.adr    (adr),
		.sel    (sel),
		.datIn  (datIn),
		.datOut (datOut),
		.ack    (ack),
		.err    (err)
	);

	cacheChecker responseCheck
	(
		.clk        (clk),
		.reset      (reset),
		.ack        (ack),
		.err        (err),
		.datOut     (datOut),
		.expAck     (expAck),
		.expData    (expData),
		.testNum    (curTest),
		.checkCount (checkCount),
		.errorCount (errorCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [dataWidth-1:0] byteMask(input logic [laneCount-1:0] lanes);
		logic [dataWidth-1:0] mask;
		for (int lane = 0; lane < laneCount; lane++)
			mask[lane*8 +: 8] = {8{lanes[lane]}};
		return mask;
	endfunction

	task automatic addWrite(
		input logic [adrWidth-1:0]  address,
		input logic [laneCount-1:0] lanes,
		input logic [dataWidth-1:0] data
	);
		logic [indexWidth-1:0] index;
		logic [tagWidth-1:0] tag;
		logic [dataWidth-1:0] mask;
		test_t entry;
		index = address[indexWidth-1:0];
		tag = address[adrWidth-1:indexWidth];
		mask = byteMask(lanes);
		if (modelValid[index] && modelTag[index] == tag)
			modelLine[index] = (modelLine[index] & ~mask) | (data & mask); // Merge on hit
		else
			modelLine[index] = data & mask; // Replace clears the other lanes
		modelValid[index] = 1'b1;
		modelTag[index] = tag;
		entry.we = 1'b1;
		entry.adr = address;
		entry.sel = lanes;
		entry.datIn = data;
		entry.expAck = 1'b1;
		entry.expData = '0;
		entry.pulseReset = pendingReset;
		tests.push_back(entry);
		pendingReset = 1'b0;
	endtask

	task automatic addRead(input logic [adrWidth-1:0] address);
		logic [indexWidth-1:0] index;
		logic hitLine;
		test_t entry;
		index = address[indexWidth-1:0];
		hitLine = modelValid[index] && modelTag[index] == address[adrWidth-1:indexWidth];
		entry.we = 1'b0;
		entry.adr = address;
		entry.sel = '1;
		entry.datIn = '0;
		entry.expAck = hitLine;
		entry.expData = hitLine ? modelLine[index] : '0;
		entry.pulseReset = pendingReset;
		tests.push_back(entry);
		pendingReset = 1'b0;
	endtask

	task automatic markReset();
		modelValid = '0;
		pendingReset = 1'b1;
	endtask

	task automatic buildTests();
		logic [dataWidth-1:0] word;
		logic [tagWidth-1:0] randTags [4];
		logic [indexWidth-1:0] indices [4] = '{6'd10, 6'd21, 6'd33, 6'd47};
		int order [4] = '{2, 0, 3, 1};
		// Empty cache
		addRead({7'h00, 6'd0});
		addRead({7'h12, 6'd5});
		addRead({7'h7f, 6'd63});
		addWrite({7'h12, 6'd5}, 8'hff, 64'h0123_4567_89ab_cdef);
		addRead({7'h12, 6'd5});
		addWrite({7'h12, 6'd5}, 8'h0f, 64'hdead_beef_5a5a_a5a5); // Low half only
		addRead({7'h12, 6'd5});
		// Same index, new tag
		word = {$urandom, $urandom};
		addWrite({7'h34, 6'd5}, 8'h30, word);
		addRead({7'h34, 6'd5});
		addRead({7'h12, 6'd5});
		for (int i = 0; i < 4; i++)
		begin
			randTags[i] = tagWidth'($urandom);
			addWrite({randTags[i], indices[i]}, 8'hff, {$urandom, $urandom});
		end
		for (int i = 0; i < 4; i++)
			addRead({randTags[order[i]], indices[order[i]]});
		markReset();
		addRead({7'h34, 6'd5});
		addRead({randTags[0], indices[0]});
	endtask

	task automatic runTest(input int n);
		if (tests[n].pulseReset)
		begin
			reset = 1'b1;
			repeat (2) @(negedge clk);
			reset = 1'b0;
		end
		@(negedge clk);
		curTest = n;
		expAck = tests[n].expAck;
		expData = tests[n].expData;
		we = tests[n].we;
		adr = tests[n].adr;
		sel = tests[n].sel;
		datIn = tests[n].datIn;
		cyc = 1'b1;
		stb = 1'b1;
		do
			@(negedge clk);
		while (!(ack || err));
		@(negedge clk); // Hold through the commit edge
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	initial
	begin
		void'($urandom(32'h1a5d_4baf));
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		sel = '0;
		datIn = '0;
		expAck = 1'b0;
		expData = '0;
		curTest = 0;
		pendingReset = 1'b0;
		modelValid = '0;
		buildTests();
		cycleLimit = 8 + 8 * tests.size() + 20;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		foreach (tests[i])
			runTest(i);
		@(negedge clk);
		$display("%0d tests, %0d responses checked, %0d errors",
			tests.size(), checkCount, errorCount);
		if (errorCount == 0 && checkCount == tests.size())
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		wait (cycleLimit > 0);
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("run timed out after %0d cycles before the table was done", cycleCount);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* cache.f */
verilog/cachePkg.sv
verilog/busControl.sv
verilog/tagStore.sv
verilog/dataStore.sv
verilog/cacheTop.sv
verification/cacheChecker.sv
verification/cacheTb.sv

/* Makefile */
TOP = cacheTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -Mdir obj_dir -f cache.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -f cache.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
